// File: include/mfifo_consts.svh
//////////////////////////////////////////////////////////////////////
// Sizing constants for the shared-storage multi-FIFO
// Logical FIFO count, RAM depth, data width and RAM read latency
//////////////////////////////////////////////////////////////////////

`ifndef MFIFO_CONSTS_SVH
`define MFIFO_CONSTS_SVH

// Number of logical FIFOs sharing the data RAM
`define NUM_FIFOS 4

// Number of entries in the shared data RAM
`define DEPTH 16

// Width of one data word in bits
`define WIDTH 16

// Cycles from a RAM read request to its response
`define RAM_RD_LAT 1

`endif

// File: logic/mfifo_cfg_pkg.sv
//////////////////////////////////////////////////////////////////////
// Configuration types for the multi-FIFO
// FIFO ids, RAM addresses, counts and the per-FIFO address range
//////////////////////////////////////////////////////////////////////

`include "mfifo_consts.svh"

package mfifo_cfg_pkg;

  // Binary id of one logical FIFO
  typedef logic [$clog2(`NUM_FIFOS)-1:0] fifo_id_t;

  // Address of one entry in the shared data RAM
  typedef logic [$clog2(`DEPTH)-1:0] addr_t;

  // Item or credit count, wide enough to hold DEPTH itself
  typedef logic [$clog2(`DEPTH + 1)-1:0] count_t;

  // Inclusive address range owned by one logical FIFO
  typedef struct packed {
    addr_t base;
    addr_t bound;
  } range_t;

  // Ranges of all logical FIFOs, index 0 holds the lowest range
  typedef range_t [`NUM_FIFOS-1:0] range_vec_t;

endpackage

// File: logic/mfifo_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Transfer types for the multi-FIFO
// Push beats and the data RAM write, read request and read response
//////////////////////////////////////////////////////////////////////

`include "mfifo_consts.svh"

package mfifo_bus_pkg;

  // One data word as stored in the RAM
  typedef logic [`WIDTH-1:0] data_t;

  // A push carries its target FIFO next to the data
  typedef struct packed {
    logic                   valid;
    mfifo_cfg_pkg::fifo_id_t fifo_id;
    data_t                  data;
  } push_beat_t;

  // Write port of the data RAM
  typedef struct packed {
    logic                 valid;
    mfifo_cfg_pkg::addr_t addr;
    data_t                data;
  } ram_wr_t;

  // Read address toward the data RAM
  typedef struct packed {
    logic                 valid;
    mfifo_cfg_pkg::addr_t addr;
  } ram_rd_req_t;

  // Read data returned RAM_RD_LAT cycles after the request
  typedef struct packed {
    logic  valid;
    data_t data;
  } ram_rd_rsp_t;

endpackage

// File: logic/mfifo_size_calc.sv
//////////////////////////////////////////////////////////////////////
// Size calculation for the multi-FIFO
// Registers each FIFO size and flags a misconfigured range set
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_size_calc (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mfifo_cfg_pkg::range_vec_t              cfg,
  output mfifo_cfg_pkg::count_t [`NUM_FIFOS-1:0] config_size,
  output logic                                   config_error
);
  import mfifo_cfg_pkg::*;

  logic [`NUM_FIFOS-1:0] bad_range;
  logic [`NUM_FIFOS-1:1] bad_order;

  // A range must hold at least one entry, and each base must sit above
  // the bound of the FIFO below it
  for (genvar i = 0; i < `NUM_FIFOS; i++) begin : g_check
    assign bad_range[i] = cfg[i].bound < cfg[i].base;
    if (i > 0) begin : g_order
      assign bad_order[i] = cfg[i].base <= cfg[i-1].bound;
    end
  end

  // Each size is bound minus base plus one of its range
  always_ff @(posedge clk) begin
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      config_size[i] <= count_t'(cfg[i].bound) - count_t'(cfg[i].base) + count_t'(1);
    end
  end

  // The error flag stays low in reset and is evaluated from then on
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      config_error <= 1'b0;
    end else begin
      config_error <= |{bad_range, bad_order};
    end
  end

endmodule

// File: logic/mfifo_push_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Push controller for the multi-FIFO
// Tail pointers, RAM writes, occupancy and per-FIFO credit return
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_push_ctrl (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mfifo_cfg_pkg::range_vec_t              cfg,
  input  mfifo_cfg_pkg::count_t [`NUM_FIFOS-1:0] config_size,
  input  mfifo_bus_pkg::push_beat_t              push,
  input  logic [`NUM_FIFOS-1:0]                  dealloc,
  output logic [`NUM_FIFOS-1:0]                  push_credit,
  output logic [`NUM_FIFOS-1:0]                  push_full,
  output mfifo_bus_pkg::ram_wr_t                 ram_wr,
  output logic [`NUM_FIFOS-1:0]                  advance_tail,
  output mfifo_cfg_pkg::addr_t [`NUM_FIFOS-1:0]  tail_next
);
  import mfifo_cfg_pkg::*;

  // Next write address of each FIFO
  addr_t [`NUM_FIFOS-1:0] tail;
  // Entries held per FIFO, counting RAM, in-flight and staged items
  count_t [`NUM_FIFOS-1:0] occupancy;

  // Decode the push into a per-FIFO strobe and compute the wrapped tail
  always_comb begin
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      advance_tail[i] = push.valid && (push.fifo_id == fifo_id_t'(i));
      if (tail[i] == cfg[i].bound) begin
        tail_next[i] = cfg[i].base;
      end else begin
        tail_next[i] = tail[i] + addr_t'(1);
      end
    end
  end

  // The push is written straight into the RAM on the edge that samples it
  assign ram_wr.valid = push.valid;
  assign ram_wr.addr  = tail[push.fifo_id];
  assign ram_wr.data  = push.data;

  // Pointer and occupancy bookkeeping
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        tail[i]      <= cfg[i].base;
        occupancy[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        if (advance_tail[i]) begin
          tail[i] <= tail_next[i];
        end
        // A push and a pop on the same FIFO cancel each other
        case ({advance_tail[i], dealloc[i]})
          2'b10:   occupancy[i] <= occupancy[i] + count_t'(1);
          2'b01:   occupancy[i] <= occupancy[i] - count_t'(1);
          default: occupancy[i] <= occupancy[i];
        endcase
      end
    end
  end

  // Full once every entry of the range is taken
  always_comb begin
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      push_full[i] = occupancy[i] == config_size[i];
    end
  end

  // Each freed entry goes back to the sender one cycle later.
  // No credits are sent at start-up since the sender begins with the sizes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      push_credit <= '0;
    end else begin
      push_credit <= dealloc;
    end
  end

endmodule

// File: logic/mfifo_ptr_mgr.sv
//////////////////////////////////////////////////////////////////////
// Pointer manager for the multi-FIFO
// Head pointers and RAM item counts, presenting each FIFO's head
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_ptr_mgr (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  mfifo_cfg_pkg::range_vec_t              cfg,
  input  logic [`NUM_FIFOS-1:0]                  advance_tail,
  input  mfifo_cfg_pkg::addr_t [`NUM_FIFOS-1:0]  tail_next,
  input  logic [`NUM_FIFOS-1:0]                  head_ready,
  output logic [`NUM_FIFOS-1:0]                  head_valid,
  output mfifo_cfg_pkg::addr_t [`NUM_FIFOS-1:0]  head,
  output mfifo_cfg_pkg::count_t [`NUM_FIFOS-1:0] ram_items,
  output logic [`NUM_FIFOS-1:0]                  ram_empty
);
  import mfifo_cfg_pkg::*;

  // Local copy of the tail, following the push controller
  addr_t [`NUM_FIFOS-1:0] tail_q;
  addr_t [`NUM_FIFOS-1:0] head_next;

  // Heads wrap from bound back to base like the tails do
  always_comb begin
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      if (head[i] == cfg[i].bound) begin
        head_next[i] = cfg[i].base;
      end else begin
        head_next[i] = head[i] + addr_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        head[i]      <= cfg[i].base;
        tail_q[i]    <= cfg[i].base;
        ram_items[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        if (head_ready[i]) begin
          head[i] <= head_next[i];
        end
        if (advance_tail[i]) begin
          tail_q[i] <= tail_next[i];
        end
        // Count only what still sits in RAM
        case ({advance_tail[i], head_ready[i]})
          2'b10:   ram_items[i] <= ram_items[i] + count_t'(1);
          2'b01:   ram_items[i] <= ram_items[i] - count_t'(1);
          default: ram_items[i] <= ram_items[i];
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      head_valid[i] = ram_items[i] != '0;
      // Head meeting tail is either empty or full, the count tells which
      ram_empty[i] = (head[i] == tail_q[i]) && !head_valid[i];
    end
  end

endmodule

// File: logic/mfifo_rr_arb.sv
//////////////////////////////////////////////////////////////////////
// Round-robin arbiter for the shared RAM read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_rr_arb (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  logic [`NUM_FIFOS-1:0]                 rd_req,
  input  mfifo_cfg_pkg::addr_t [`NUM_FIFOS-1:0] head,
  output logic [`NUM_FIFOS-1:0]                 rd_grant,
  output mfifo_bus_pkg::ram_rd_req_t            ram_rd_req
);
  import mfifo_cfg_pkg::*;

  // FIFO with the highest priority in the current cycle
  fifo_id_t prio;
  fifo_id_t cand;
  fifo_id_t winner;
  logic     found;

  // Scan from the priority pointer upward and take the first requester
  always_comb begin
    rd_grant = '0;
    winner   = prio;
    found    = 1'b0;
    cand     = prio;
    for (int k = 0; k < `NUM_FIFOS; k++) begin
      cand = prio + fifo_id_t'(k);
      if (!found && rd_req[cand]) begin
        found          = 1'b1;
        winner         = cand;
        rd_grant[cand] = 1'b1;
      end
    end
  end

  assign ram_rd_req.valid = found;
  assign ram_rd_req.addr  = head[winner];

  // The winner drops to the lowest priority after its grant
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prio <= '0;
    end else if (found) begin
      prio <= winner + fifo_id_t'(1);
    end
  end

endmodule

// File: logic/mfifo_stage_buf.sv
//////////////////////////////////////////////////////////////////////
// One-entry pop staging buffer for a single logical FIFO
// Refills from the shared RAM and serves the ready/valid pop port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_stage_buf (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       head_valid,
  input  logic                       rd_grant,
  input  mfifo_bus_pkg::ram_rd_rsp_t ram_rd_rsp,
  input  logic                       pop_ready,
  output logic                       rd_req,
  output logic                       head_ready,
  output logic                       pop_valid,
  output mfifo_bus_pkg::data_t       pop_data,
  output logic                       pop_empty,
  output logic                       dealloc
);
  import mfifo_bus_pkg::*;

  logic                   slot_valid;
  data_t                  slot_data;
  // One bit per cycle of RAM latency, the top bit marks our response
  logic [`RAM_RD_LAT-1:0] in_flight;
  logic                   capture;

  // Ask for the read port only with an empty slot and nothing on its way
  assign rd_req     = !slot_valid && (in_flight == '0) && head_valid;
  assign head_ready = rd_grant;

  // Only the buffer with the in-flight flag takes the response
  assign capture = in_flight[`RAM_RD_LAT-1] && ram_rd_rsp.valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      in_flight  <= '0;
      slot_valid <= 1'b0;
    end else begin
      in_flight <= (in_flight << 1) | `RAM_RD_LAT'(rd_grant);
      if (capture) begin
        slot_valid <= 1'b1;
      end else if (dealloc) begin
        slot_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      slot_data <= ram_rd_rsp.data;
    end
  end

  assign pop_valid = slot_valid;
  assign pop_data  = slot_data;
  // A completed pop frees one entry of the FIFO's range
  assign dealloc   = slot_valid && pop_ready;
  // Empty when nothing is staged, pending or left in RAM
  assign pop_empty = !slot_valid && (in_flight == '0) && !head_valid;

endmodule

// File: logic/mfifo_data_ram.sv
//////////////////////////////////////////////////////////////////////
// Shared data RAM with one write port and one registered read port
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_data_ram (
  input  logic                       clk,
  input  mfifo_bus_pkg::ram_wr_t     ram_wr,
  input  mfifo_bus_pkg::ram_rd_req_t ram_rd_req,
  output mfifo_bus_pkg::ram_rd_rsp_t ram_rd_rsp
);
  import mfifo_bus_pkg::*;

  data_t mem [`DEPTH];

  always_ff @(posedge clk) begin
    if (ram_wr.valid) begin
      mem[ram_wr.addr] <= ram_wr.data;
    end
  end

  // Read data is held between requests, the valid bit trails by a cycle
  always_ff @(posedge clk) begin
    ram_rd_rsp.valid <= ram_rd_req.valid;
    if (ram_rd_req.valid) begin
      ram_rd_rsp.data <= mem[ram_rd_req.addr];
    end
  end

endmodule

// File: logic/mfifo_top.sv
//////////////////////////////////////////////////////////////////////
// Shared-storage multi-FIFO with pseudo-static allocation
// Valid/credit push side, one ready/valid pop port per logical FIFO
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_top (
  input  logic                                  clk,
  input  logic                                  rst_n,
  input  mfifo_cfg_pkg::range_vec_t             cfg,
  output logic                                  config_error,
  input  mfifo_bus_pkg::push_beat_t             push,
  output logic [`NUM_FIFOS-1:0]                 push_credit,
  output logic [`NUM_FIFOS-1:0]                 push_full,
  input  logic [`NUM_FIFOS-1:0]                 pop_ready,
  output logic [`NUM_FIFOS-1:0]                 pop_valid,
  output mfifo_bus_pkg::data_t [`NUM_FIFOS-1:0] pop_data,
  output logic [`NUM_FIFOS-1:0]                 pop_empty
);
  import mfifo_cfg_pkg::*;
  import mfifo_bus_pkg::*;

  count_t [`NUM_FIFOS-1:0] config_size;
  logic [`NUM_FIFOS-1:0]   advance_tail;
  addr_t [`NUM_FIFOS-1:0]  tail_next;
  logic [`NUM_FIFOS-1:0]   dealloc;
  logic [`NUM_FIFOS-1:0]   head_ready;
  logic [`NUM_FIFOS-1:0]   head_valid;
  addr_t [`NUM_FIFOS-1:0]  head;
  logic [`NUM_FIFOS-1:0]   rd_req;
  logic [`NUM_FIFOS-1:0]   rd_grant;
  ram_wr_t                 ram_wr;
  ram_rd_req_t             ram_rd_req;
  ram_rd_rsp_t             ram_rd_rsp;

  mfifo_size_calc u_size_calc (
    .clk, .rst_n, .cfg, .config_size, .config_error
  );

  mfifo_push_ctrl u_push_ctrl (
    .clk, .rst_n, .cfg, .config_size, .push, .dealloc,
    .push_credit, .push_full, .ram_wr, .advance_tail, .tail_next
  );

  // RAM item counts and section empty flags are not needed at this level
  mfifo_ptr_mgr u_ptr_mgr (
    .clk, .rst_n, .cfg, .advance_tail, .tail_next, .head_ready,
    .head_valid, .head, .ram_items(), .ram_empty()
  );

  mfifo_rr_arb u_rr_arb (
    .clk, .rst_n, .rd_req, .head, .rd_grant, .ram_rd_req
  );

  // Staging buffers are peers and all watch the same read response
  for (genvar i = 0; i < `NUM_FIFOS; i++) begin : g_stage
    mfifo_stage_buf u_stage_buf (
      .clk, .rst_n,
      .head_valid(head_valid[i]), .rd_grant(rd_grant[i]), .ram_rd_rsp,
      .pop_ready(pop_ready[i]), .rd_req(rd_req[i]), .head_ready(head_ready[i]),
      .pop_valid(pop_valid[i]), .pop_data(pop_data[i]),
      .pop_empty(pop_empty[i]), .dealloc(dealloc[i])
    );
  end

  mfifo_data_ram u_data_ram (
    .clk, .ram_wr, .ram_rd_req, .ram_rd_rsp
  );

endmodule

// File: bench/mfifo_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the shared-storage multi-FIFO
// Credit-tracking sender, model queues and a comparing process
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps
`include "mfifo_consts.svh"

module mfifo_tb;
  import mfifo_cfg_pkg::*;
  import mfifo_bus_pkg::*;

  logic                         clk;
  logic                         rst_n;
  range_vec_t                   cfg;
  push_beat_t                   push;
  logic [`NUM_FIFOS-1:0]        pop_ready;
  logic                         config_error;
  logic [`NUM_FIFOS-1:0]        push_credit;
  logic [`NUM_FIFOS-1:0]        push_full;
  logic [`NUM_FIFOS-1:0]        pop_valid;
  data_t [`NUM_FIFOS-1:0]       pop_data;
  logic [`NUM_FIFOS-1:0]        pop_empty;

  // Expected words of each FIFO in the order they were accepted
  data_t                        model_q[`NUM_FIFOS][$];
  int                           size_of[`NUM_FIFOS];
  // Pushes sent, credit pulses seen and pops seen per FIFO
  int                           sent[`NUM_FIFOS];
  int                           returned[`NUM_FIFOS];
  int                           pops[`NUM_FIFOS];
  // Zero credit must come with push_full on FIFOs that see no pops
  logic [`NUM_FIFOS-1:0]        full_watch;
  int unsigned                  lcg_state = 31;
  int                           errors = 0;

  mfifo_top dut (
    .clk, .rst_n, .cfg, .config_error, .push, .push_credit, .push_full,
    .pop_ready, .pop_valid, .pop_data, .pop_empty
  );

  always #2 clk = ~clk;

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  // Each range holds bound minus base plus one entries
  function automatic int range_size(input range_t r);
    return int'(r.bound) - int'(r.base) + 1;
  endfunction

  // Expected config_error is set by an inverted range or by ranges out of ascending order
  function automatic logic config_bad(input range_vec_t c);
    logic bad;
    bad = 1'b0;
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      if (c[i].bound < c[i].base) bad = 1'b1;
    end
    for (int i = 1; i < `NUM_FIFOS; i++) begin
      if (c[i].base <= c[i-1].bound) bad = 1'b1;
    end
    return bad;
  endfunction

  function automatic range_vec_t make_ranges(input int b0, e0, b1, e1, b2, e2, b3, e3);
    range_vec_t c;
    c[0] = '{base: addr_t'(b0), bound: addr_t'(e0)};
    c[1] = '{base: addr_t'(b1), bound: addr_t'(e1)};
    c[2] = '{base: addr_t'(b2), bound: addr_t'(e2)};
    c[3] = '{base: addr_t'(b3), bound: addr_t'(e3)};
    return c;
  endfunction

  function automatic int credits_left(input int i);
    return size_of[i] - sent[i] + returned[i];
  endfunction

  // True once every word is popped and every credit is back
  function automatic logic all_drained();
    logic done;
    done = 1'b1;
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      if (model_q[i].size() != 0 || credits_left(i) != size_of[i]) done = 1'b0;
    end
    return done;
  endfunction

  task automatic check_equal(input int unsigned actual, input int unsigned expected,
                             input string what);
    if (actual != expected) begin
      errors++;
      $display("FAILED at time %0t: %s, expected %0h, got %0h", $time, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1);
    end
  endtask

  task automatic abort_run(input string msg);
    errors++;
    $display("%s", msg);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  // Drives one clock of the sender and sends a push only while a credit is held
  task automatic send(input logic en, input fifo_id_t id, input data_t d);
    @(posedge clk);
    if (en && credits_left(int'(id)) > 0) begin
      push <= '{valid: 1'b1, fifo_id: id, data: d};
      sent[id]++;
    end else begin
      push <= '0;
    end
  endtask

  task automatic wait_drained(input string what);
    int n;
    n = 0;
    while (!all_drained()) begin
      send(1'b0, '0, '0);
      n++;
      if (n > 200) abort_run({"Timeout while draining after ", what});
    end
  endtask

  task automatic apply_reset(input range_vec_t c);
    @(posedge clk);
    rst_n      <= 1'b0;
    cfg        <= c;
    push       <= '0;
    pop_ready  <= '0;
    full_watch = '0;
    for (int i = 0; i < `NUM_FIFOS; i++) begin
      sent[i]    = 0;
      size_of[i] = range_size(c[i]);
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    // The error flag is evaluated on the first edge out of reset
    @(posedge clk);
    @(negedge clk);
    check_equal(config_error, config_bad(c), "config_error after reset");
    check_equal(pop_empty, {`NUM_FIFOS{1'b1}}, "pop_empty after reset");
  endtask

  // Mid-cycle the values are those that the DUT samples on the next edge
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        model_q[i].delete();
        pops[i]     = 0;
        returned[i] = 0;
      end
    end else begin
      for (int i = 0; i < `NUM_FIFOS; i++) begin
        // Words accepted earlier and not yet popped keep the FIFO from empty
        check_equal(pop_empty[i], model_q[i].size() == 0,
                    $sformatf("pop_empty of FIFO %0d", i));
        if (pop_valid[i] && pop_ready[i]) begin
          if (model_q[i].size() == 0) begin
            abort_run($sformatf("FIFO %0d delivered a word that was never pushed", i));
          end else begin
            check_equal(pop_data[i], model_q[i][0], $sformatf("pop data of FIFO %0d", i));
            void'(model_q[i].pop_front());
            pops[i]++;
          end
        end
        if (push_credit[i]) returned[i]++;
        // Credits trail their pops by a cycle and never run ahead
        check_equal(returned[i] <= pops[i], 1, $sformatf("credits of FIFO %0d vs pops", i));
        if (full_watch[i] && credits_left(i) == 0 &&
            !(push.valid && push.fifo_id == fifo_id_t'(i))) begin
          check_equal(push_full[i], 1, $sformatf("push_full of FIFO %0d at zero credit", i));
        end
      end
      if (push.valid) begin
        // A push sent with a credit never meets a FIFO already at its size
        check_equal(push_full[push.fifo_id], 0, "push_full on an accepted push");
        model_q[push.fifo_id].push_back(push.data);
      end
    end
  end

  initial begin
    int       n;
    fifo_id_t id;
    clk        = 1'b0;
    rst_n      = 1'b0;
    cfg        = '0;
    push       = '0;
    pop_ready  = '0;
    full_watch = '0;

    // Uneven legal ranges, then an inverted range and an overlap
    apply_reset(make_ranges(0, 5, 6, 7, 8, 10, 11, 15));
    apply_reset(make_ranges(0, 5, 7, 6, 8, 10, 11, 15));
    apply_reset(make_ranges(0, 5, 5, 7, 8, 10, 11, 15));
    apply_reset(make_ranges(0, 5, 6, 7, 8, 10, 11, 15));

    // Random traffic to random FIFOs under random back-pressure
    for (int k = 0; k < 600; k++) begin
      id = fifo_id_t'(next_rand());
      send(next_rand() % 4 != 0, id, data_t'(next_rand()));
      pop_ready <= 4'(next_rand());
    end
    pop_ready <= '1;
    wait_drained("random traffic");

    // FIFO 2 is held and filled to its size
    pop_ready  <= 4'b1011;
    full_watch = 4'b0100;
    n = 0;
    while (credits_left(2) > 0) begin
      send(1'b1, 2'd2, data_t'(next_rand()));
      n++;
      if (n > 50) abort_run("Timeout while filling the held FIFO");
    end
    // The other three keep moving while FIFO 2 is stuck
    for (int k = 0; k < 300; k++) begin
      id = fifo_id_t'(next_rand() % 3);
      if (id == 2'd2) id = 2'd3;
      send(1'b1, id, data_t'(next_rand()));
      pop_ready <= 4'(next_rand()) & 4'b1011;
    end
    pop_ready <= 4'b1011;
    n = 0;
    while (model_q[0].size() + model_q[1].size() + model_q[3].size() != 0) begin
      send(1'b0, '0, '0);
      n++;
      if (n > 100) abort_run("Timeout: traffic on the other FIFOs stalled");
    end
    check_equal(model_q[2].size(), size_of[2], "level of the held FIFO");
    full_watch = '0;
    pop_ready  <= '1;
    wait_drained("releasing the held FIFO");

    // Load all four completely, then let the arbiter share the read port
    pop_ready  <= '0;
    full_watch = '1;
    n = 0;
    while (credits_left(0) + credits_left(1) + credits_left(2) + credits_left(3) > 0) begin
      send(1'b1, fifo_id_t'(n), data_t'(next_rand()));
      n++;
      if (n > 100) abort_run("Timeout while loading all FIFOs");
    end
    full_watch = '0;
    pop_ready  <= '1;
    wait_drained("loading all FIFOs");
    @(negedge clk);
    check_equal(pop_empty, {`NUM_FIFOS{1'b1}}, "pop_empty after draining");

    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+include
logic/mfifo_cfg_pkg.sv
logic/mfifo_bus_pkg.sv
logic/mfifo_size_calc.sv
logic/mfifo_push_ctrl.sv
logic/mfifo_ptr_mgr.sv
logic/mfifo_rr_arb.sv
logic/mfifo_stage_buf.sv
logic/mfifo_data_ram.sv
logic/mfifo_top.sv
bench/mfifo_tb.sv

// File: run.sh
#!/bin/sh
# Build the multi-FIFO testbench with Verilator, run it and judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module mfifo_tb -o mfifo_sim \
  && ./obj_dir/mfifo_sim > sim.log 2>&1 \
  || echo "Build or simulation returned an error" >> sim.log
! grep -q "ERRORS FOUND" sim.log && grep -q "NO ERRORS" sim.log && echo "PASS" && exit 0
echo "FAIL"
exit 1
